// ==== compile.f ====
source/can_pkg.sv
source/can_cmd_ctrl.sv
source/can_cfg_regs.sv
source/can_tx_assembler.sv
source/can_rx_fifo.sv
source/can_upload_engine.sv
source/can_handler.sv
test/tb_can_handler.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_can_handler
LINT_TOP  ?= can_handler
FLAGS     ?= --timing -Wno-fatal
OBJ_DIR   ?= obj_dir
SOURCES   := $(shell grep -v '^+' compile.f)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): compile.f $(SOURCES)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f compile.f

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(LINT_TOP) -f compile.f

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_can_handler.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_can_handler;
    import can_pkg::*;

    localparam int test_cycles = 260;  // rough sum over all tests

    logic        clk = 1'b0;
    logic        rst_n;
    logic        cmd_start;
    logic        cmd_done;
    cmd_bus_t    cmd;
    logic        cmd_ready;
    can_cfg_t    cfg;
    logic        tx_valid;
    can_tx_req_t tx_req;
    logic        tx_ready;
    logic        rx_valid;
    logic [7:0]  rx_data;
    logic        upload_ready;
    logic        upload_active;
    logic        upload_valid;
    logic        upload_req;
    logic [7:0]  upload_data;

    int          errors = 0;
    int          cyc = 0;
    int          done_cyc = 0;
    int          tx_cyc = 0;
    int          tx_count = 0;
    int          up_count = 0;
    logic [31:0] rng = 32'd51463;
    logic        up_random = 1'b0;     // host back-pressure on/off
    string       test_name = "reset";
    can_tx_req_t exp_tx;
    logic [7:0]  exp_up [$];           // bytes still owed on upload

    can_handler dut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // ====================
    // helpers
    // ====================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] rand_byte();
        rng = xorshift32(rng);
        return rng[7:0];
    endfunction

    // message byte i sits at msg[8*i +: 8], so fields read out low byte first
    function automatic can_cfg_t ref_cfg(input logic [127:0] msg);
        can_cfg_t c;
        c.local_id     = msg[0 +: 11];
        c.short_filter = msg[16 +: 11];
        c.short_mask   = msg[32 +: 11];
        c.long_filter  = msg[48 +: 29];
        c.long_mask    = msg[80 +: 29];
        c.c_pts        = msg[112 +: 16];
        return c;
    endfunction

    function automatic can_tx_req_t ref_tx(input logic [127:0] bytes, input int n);
        can_tx_req_t r;
        r.data = '0;
        for (int i = 0; i < n && i < tx_max_bytes; i++) begin
            r.data[31 - 8*i -: 8] = bytes[8*i +: 8];  // first byte on top
        end
        r.len = (n >= 1 && n <= tx_max_bytes) ? 4'(n) : 4'(tx_max_bytes);
        return r;
    endfunction

    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] exp_v,
                                   input logic [127:0] act_v);
        errors++;
        $display("mismatch %s: expected %h, actual %h", name, exp_v, act_v);
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("error in %s: %s at cycle %0d", test_name, what, cyc);
    endtask

    task automatic wait_idle();
        while (!cmd_ready) tick();
    endtask

    task automatic send_cmd(input logic [7:0] code, input int n, input logic [127:0] bytes);
        wait_idle();
        cmd.cmd_type = code;
        cmd.length   = 16'(n);
        cmd_start    = 1'b1;
        tick();
        cmd_start = 1'b0;
        for (int i = 0; i < n; i++) begin
            cmd.data       = bytes[8*i +: 8];
            cmd.index      = 16'(i);
            cmd.data_valid = 1'b1;
            cmd_done       = (i == n - 1);  // done rides on the last byte
            done_cyc       = cyc;
            tick();
        end
        if (n == 0) begin
            cmd_done = 1'b1;
            done_cyc = cyc;
            tick();
        end
        cmd_done       = 1'b0;
        cmd.data_valid = 1'b0;
    endtask

    // core model, takes the frame three cycles after the pulse
    initial begin
        tx_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (tx_valid) begin
                repeat (3) @(posedge clk);
                #5 tx_ready = 1'b1;
                @(posedge clk);
                #5 tx_ready = 1'b0;
            end
        end
    end

    // host upload side
    initial begin
        logic next_ready;
        upload_ready = 1'b1;
        forever begin
            @(posedge clk);
            if (up_random) begin
                next_ready = (rand_byte() > 8'd96);
            end else begin
                next_ready = 1'b1;
            end
            #5 upload_ready = next_ready;
        end
    end

    // ====================
    // compare process
    // ====================
    always @(negedge clk) begin
        if (tx_valid) begin
            tx_count++;
            tx_cyc = cyc;
            if (tx_req !== exp_tx) report_mismatch(test_name, exp_tx, tx_req);
            if (cmd_ready) report_error("cmd_ready high while frame pending");
        end
        if (upload_valid) begin
            up_count++;
            if (!upload_req) report_error("upload_req low during upload_valid");
            if (exp_up.size() == 0) begin
                report_error("upload byte with none expected");
            end else begin
                if (upload_data !== exp_up[0]) report_mismatch(test_name, exp_up[0], upload_data);
                void'(exp_up.pop_front());
            end
        end
    end

    initial begin
        repeat (20 * test_cycles) @(posedge clk);
        $display("timeout: run stopped after %0d cycles", cyc);
        $display("sim failed");
        $finish;
    end

    // ====================
    // stimulus
    // ====================
    initial begin
        logic [127:0] msg;
        can_cfg_t     exp_cfg;
        can_cfg_t     saved_cfg;
        int           tx_before;
        int           up_before;
        int           lens [4];

        rst_n     = 1'b0;
        cmd_start = 1'b0;
        cmd_done  = 1'b0;
        cmd       = '0;
        rx_valid  = 1'b0;
        rx_data   = 8'h00;
        exp_tx    = '0;
        lens      = '{0, 2, 4, 7};
        repeat (10) @(posedge clk);
        #5 rst_n = 1'b1;
        tick();

        if (!cmd_ready) report_error("cmd_ready low after reset");
        if (tx_valid || upload_valid || upload_req || upload_active) begin
            report_error("strobe high after reset");
        end
        if (cfg !== cfg_default) report_mismatch(test_name, cfg_default, cfg);

        test_name = "config";
        for (int i = 0; i < cfg_bytes; i++) msg[8*i +: 8] = rand_byte();
        exp_cfg = ref_cfg(msg);
        send_cmd(cmd_can_config, cfg_bytes, msg);
        if (cmd_ready) report_error("cmd_ready high before config update");
        tick();
        if (!cmd_ready) report_error("cmd_ready low two cycles after cmd_done");
        if (cfg !== exp_cfg) report_mismatch(test_name, exp_cfg, cfg);

        foreach (lens[k]) begin
            test_name = $sformatf("transmit len %0d", lens[k]);
            msg = '0;
            for (int i = 0; i < lens[k]; i++) msg[8*i +: 8] = rand_byte();
            exp_tx    = ref_tx(msg, lens[k]);
            tx_before = tx_count;
            send_cmd(cmd_can_tx, lens[k], msg);
            wait_idle();
            if (tx_count != tx_before + 1) begin
                report_error("expected exactly one tx_valid pulse");
            end else if (tx_cyc != done_cyc + 2) begin
                report_mismatch({test_name, " latency"}, done_cyc + 2, tx_cyc);
            end
        end

        test_name = "upload";
        up_before = up_count;
        for (int i = 0; i < 20; i++) begin
            rx_data  = rand_byte();
            rx_valid = 1'b1;
            if (i < rx_depth) exp_up.push_back(rx_data);  // the rest overflow
            tick();
        end
        rx_valid  = 1'b0;
        up_random = 1'b1;
        send_cmd(cmd_can_rx, 0, '0);
        wait_idle();
        up_random = 1'b0;
        if (up_count != up_before + rx_depth) begin
            report_mismatch(test_name, rx_depth, up_count - up_before);
        end
        if (exp_up.size() != 0) report_error("bytes missing from upload");
        if (upload_active) report_error("upload_active still high");

        test_name = "empty read";
        up_before = up_count;
        send_cmd(cmd_can_rx, 0, '0);
        if (!cmd_ready) report_error("cmd_ready not back after empty read");
        if (up_count != up_before) report_error("upload from empty FIFO");

        test_name = "unknown code";
        saved_cfg = cfg;
        tx_before = tx_count;
        up_before = up_count;
        msg       = {112'h0, rand_byte(), rand_byte()};
        send_cmd(8'h5A, 2, msg);
        repeat (4) tick();
        if (cfg !== saved_cfg) report_mismatch(test_name, saved_cfg, cfg);
        if (tx_count != tx_before || up_count != up_before) report_error("unexpected activity");
        if (!cmd_ready) report_error("cmd_ready low after unknown code");
        if (upload_req) report_error("upload_req high with no upload pending");

        tick();
        $display("errors %0d, tx pulses %0d, upload bytes %0d", errors, tx_count, up_count);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/can_handler.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_handler (
    input  logic                  clk,
    input  logic                  rst_n,
    // host command side
    input  logic                  cmd_start,
    input  logic                  cmd_done,
    input  can_pkg::cmd_bus_t     cmd,
    output logic                  cmd_ready,
    // core side
    output can_pkg::can_cfg_t     cfg,
    output logic                  tx_valid,
    output can_pkg::can_tx_req_t  tx_req,
    input  logic                  tx_ready,
    input  logic                  rx_valid,
    input  logic [7:0]            rx_data,
    // upload side
    input  logic                  upload_ready,
    output logic                  upload_active,
    output logic                  upload_valid,
    output logic                  upload_req,
    output logic [7:0]            upload_data
);

    logic       cfg_capture;
    logic       cfg_update;
    logic       tx_collect;
    logic       tx_fire;
    logic       fifo_empty;
    logic       fifo_pop;
    logic [7:0] fifo_data;

    // ====================
    // control
    // ====================
    can_cmd_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_start     (cmd_start),
        .cmd_done      (cmd_done),
        .cmd_type      (cmd.cmd_type),
        .fifo_empty    (fifo_empty),
        .tx_ready      (tx_ready),
        .cmd_ready     (cmd_ready),
        .cfg_capture   (cfg_capture),
        .cfg_update    (cfg_update),
        .tx_collect    (tx_collect),
        .tx_fire       (tx_fire),
        .upload_active (upload_active)
    );

    can_cfg_regs u_cfg (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (cmd),
        .cfg_capture (cfg_capture),
        .cfg_update  (cfg_update),
        .cfg         (cfg)
    );

    can_tx_assembler u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_start  (cmd_start),
        .cmd        (cmd),
        .tx_collect (tx_collect),
        .tx_fire    (tx_fire),
        .tx_valid   (tx_valid),
        .tx_req     (tx_req)
    );

    // receive path
    can_rx_fifo u_rx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rx_valid),
        .push_data (rx_data),
        .pop       (fifo_pop),
        .pop_data  (fifo_data),
        .empty     (fifo_empty)
    );

    can_upload_engine u_upload (
        .clk           (clk),
        .rst_n         (rst_n),
        .upload_active (upload_active),
        .fifo_empty    (fifo_empty),
        .fifo_data     (fifo_data),
        .upload_ready  (upload_ready),
        .pop           (fifo_pop),
        .upload_valid  (upload_valid),
        .upload_req    (upload_req),
        .upload_data   (upload_data)
    );

endmodule

`default_nettype wire

// ==== source/can_upload_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_upload_engine (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       upload_active,
    input  logic       fifo_empty,
    input  logic [7:0] fifo_data,
    input  logic       upload_ready,
    output logic       pop,
    output logic       upload_valid,
    output logic       upload_req,
    output logic [7:0] upload_data
);

    typedef enum logic [1:0] {
        up_idle,
        up_send,
        up_wait
    } up_state_t;

    up_state_t state;

    // launch only when the host can take it
    assign pop = (state == up_idle) && upload_active && upload_ready && !fifo_empty;

    // ====================
    // handshake FSM
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= up_idle;
        end else begin
            case (state)
                up_idle: if (pop) state <= up_send;
                up_send: state <= up_wait;
                up_wait: if (upload_ready) state <= up_idle;  // byte taken
                default: state <= up_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            upload_data <= fifo_data;
        end
    end

    assign upload_valid = (state == up_send);
    assign upload_req   = (state == up_send) || (state == up_wait);

endmodule

`default_nettype wire

// ==== source/can_rx_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_rx_fifo (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       pop,
    output logic [7:0] pop_data,
    output logic       empty
);
    import can_pkg::*;

    logic [7:0]                  mem [rx_depth];
    logic [$clog2(rx_depth)-1:0] wr_ptr;
    logic [$clog2(rx_depth)-1:0] rd_ptr;
    logic [$clog2(rx_depth):0]   count;
    logic                        full;
    logic                        do_push;
    logic                        do_pop;

    assign full    = (count == rx_depth);
    assign empty   = (count == '0);
    assign do_push = push && !full;   // overflow bytes dropped
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign pop_data = mem[rd_ptr];  // oldest byte

endmodule

`default_nettype wire

// ==== source/can_tx_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_tx_assembler (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmd_start,
    input  can_pkg::cmd_bus_t     cmd,
    input  logic                  tx_collect,
    input  logic                  tx_fire,
    output logic                  tx_valid,
    output can_pkg::can_tx_req_t  tx_req
);
    import can_pkg::*;

    logic [7:0] tx_buf [tx_max_bytes];
    logic [2:0] wr_ptr;     // counts up to tx_max_bytes
    logic [3:0] len_q;      // clamped length
    logic       tx_start;
    logic       wr_en;

    assign tx_start = cmd_start && (cmd.cmd_type == cmd_can_tx);
    assign wr_en    = tx_collect && cmd.data_valid && (wr_ptr < tx_max_bytes);

    // ====================
    // byte buffer
    // ====================
    always_ff @(posedge clk) begin
        if (tx_start) begin
            for (int i = 0; i < tx_max_bytes; i++) begin
                tx_buf[i] <= 8'h00;  // short frames are zero filled
            end
        end else if (wr_en) begin
            tx_buf[wr_ptr[1:0]] <= cmd.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            len_q  <= 4'(tx_max_bytes);
        end else if (tx_start) begin
            wr_ptr <= '0;
            if ((cmd.length >= 16'd1) && (cmd.length <= tx_max_bytes)) begin
                len_q <= cmd.length[3:0];
            end else begin
                len_q <= 4'(tx_max_bytes);
            end
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 3'd1;
        end
    end

    // frame request, byte 0 goes out first
    always_ff @(posedge clk) begin
        if (tx_fire) begin
            tx_req.data <= {tx_buf[0], tx_buf[1], tx_buf[2], tx_buf[3]};
            tx_req.len  <= len_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= tx_fire;  // one pulse per fire
        end
    end

endmodule

`default_nettype wire

// ==== source/can_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_cfg_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  can_pkg::cmd_bus_t  cmd,
    input  logic               cfg_capture,
    input  logic               cfg_update,
    output can_pkg::can_cfg_t  cfg
);
    import can_pkg::*;

    logic [7:0] stage [cfg_bytes];  // raw config message

    // staging bytes, placed by host index
    always_ff @(posedge clk) begin
        if (cfg_capture && cmd.data_valid && (cmd.index < cfg_bytes)) begin
            stage[cmd.index[$clog2(cfg_bytes)-1:0]] <= cmd.data;
        end
    end

    // ====================
    // unpack, low byte first
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= cfg_default;
        end else if (cfg_update) begin
            cfg.local_id     <= {stage[1][2:0], stage[0]};
            cfg.short_filter <= {stage[3][2:0], stage[2]};
            cfg.short_mask   <= {stage[5][2:0], stage[4]};
            // 29 bit ids span four bytes, top bits of the last byte unused
            cfg.long_filter  <= {stage[9][4:0], stage[8], stage[7], stage[6]};
            cfg.long_mask    <= {stage[13][4:0], stage[12], stage[11], stage[10]};
            cfg.c_pts        <= {stage[15], stage[14]};
        end
    end

endmodule

`default_nettype wire

// ==== source/can_cmd_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_cmd_ctrl (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cmd_start,
    input  logic       cmd_done,
    input  logic [7:0] cmd_type,
    input  logic       fifo_empty,
    input  logic       tx_ready,
    output logic       cmd_ready,
    output logic       cfg_capture,
    output logic       cfg_update,
    output logic       tx_collect,
    output logic       tx_fire,
    output logic       upload_active
);
    import can_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_cfg_capture,
        st_cfg_update,
        st_tx_collect,
        st_tx_fire,
        st_tx_wait,
        st_rx_check,
        st_upload
    } state_t;

    state_t state;
    state_t state_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // ====================
    // next state
    // ====================
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (cmd_start) begin
                    case (cmd_type)
                        cmd_can_config: state_nxt = st_cfg_capture;
                        cmd_can_tx:     state_nxt = st_tx_collect;
                        cmd_can_rx:     state_nxt = st_rx_check;
                        default:        state_nxt = st_idle;  // unknown code, ignored
                    endcase
                end
            end
            st_cfg_capture: if (cmd_done) state_nxt = st_cfg_update;
            st_cfg_update:  state_nxt = st_idle;
            st_tx_collect:  if (cmd_done) state_nxt = st_tx_fire;
            st_tx_fire:     state_nxt = st_tx_wait;  // last byte settles here
            st_tx_wait:     if (tx_ready) state_nxt = st_idle;
            st_rx_check:    state_nxt = fifo_empty ? st_idle : st_upload;
            st_upload:      if (fifo_empty) state_nxt = st_idle;
            default:        state_nxt = st_idle;
        endcase
    end

    // steering for the datapath blocks
    assign cmd_ready     = (state == st_idle);
    assign cfg_capture   = (state == st_cfg_capture);
    assign cfg_update    = (state == st_cfg_update);   // single cycle
    assign tx_collect    = (state == st_tx_collect);
    assign tx_fire       = (state == st_tx_fire);      // single cycle
    assign upload_active = (state == st_upload);

endmodule

`default_nettype wire

// ==== source/can_pkg.sv ====
`default_nettype none

package can_pkg;

    // ====================
    // command codes
    // ====================
    localparam logic [7:0] cmd_can_config = 8'h27;  // load node config
    localparam logic [7:0] cmd_can_tx     = 8'h28;  // send one data frame
    localparam logic [7:0] cmd_can_rx     = 8'h29;  // drain received bytes

    // ====================
    // sizes
    // ====================
    localparam int cfg_bytes    = 16;
    localparam int tx_max_bytes = 4;
    localparam int rx_depth     = 16;

    // host command bus, one data byte per beat
    typedef struct packed {
        logic [7:0]  cmd_type;
        logic [15:0] length;
        logic [7:0]  data;
        logic [15:0] index;
        logic        data_valid;
    } cmd_bus_t;

    // runtime configuration handed to the core
    typedef struct packed {
        logic [10:0] local_id;
        logic [10:0] short_filter;
        logic [10:0] short_mask;
        logic [28:0] long_filter;
        logic [28:0] long_mask;
        logic [15:0] c_pts;       // propagation segment
    } can_cfg_t;

    // frame request, data is big endian
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  len;
    } can_tx_req_t;

    // defaults for 1 MHz bit rate on a 60 MHz clock
    localparam can_cfg_t cfg_default = '{
        local_id:     11'h001,
        short_filter: 11'h002,
        short_mask:   11'h7FF,
        long_filter:  29'h12345678,
        long_mask:    29'h1FFFFFFF,
        c_pts:        16'd34
    };

endpackage

`default_nettype wire
